// ==== common/i3c_daa_pkg.sv ====
`default_nettype none

package i3c_daa_pkg;

  // One received byte, read either as a header or as an assigned address
  typedef union packed {
    struct packed {
      logic [6:0] addr;
      logic       rnw;
    } hdr;
    struct packed {
      logic [6:0] addr;
      logic       parity;
    } daa;
  } rx_byte_u;

  // Broadcast address and CCC code
  localparam logic [6:0] RSVD_ADDR  = 7'h7E;
  localparam logic [7:0] CCC_ENTDAA = 8'h07;

  // 48-bit provisional ID followed by BCR and DCR
  localparam int unsigned ID_BITS = 64;

  // APB register offsets
  localparam logic [4:0] CSR_PID_LO   = 5'h00;
  localparam logic [4:0] CSR_PID_HI   = 5'h04;
  localparam logic [4:0] CSR_CHAR     = 5'h08;
  localparam logic [4:0] CSR_DYN_ADDR = 5'h0C;
  localparam logic [4:0] CSR_STATUS   = 5'h10;

endpackage

`default_nettype wire

// ==== bus_phy/bus_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_monitor #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic start_o,
  output logic rstart_o,
  output logic stop_o
);

  logic [SYNC_STAGES-1:0] scl_sync_q;
  logic [SYNC_STAGES-1:0] sda_sync_q;
  logic                   scl_s;
  logic                   sda_s;
  logic                   start_det;
  logic                   stop_det;
  logic                   bus_busy_q;

  assign scl_s = scl_sync_q[SYNC_STAGES-1];
  assign sda_s = sda_sync_q[SYNC_STAGES-1];

  // SDA edges while SCL stays high
  assign start_det = scl_s && scl_o && sda_o && !sda_s;
  assign stop_det  = scl_s && scl_o && !sda_o && sda_s;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_o      <= 1'b1;
      sda_o      <= 1'b1;
      scl_rise_o <= 1'b0;
      scl_fall_o <= 1'b0;
      start_o    <= 1'b0;
      rstart_o   <= 1'b0;
      stop_o     <= 1'b0;
      bus_busy_q <= 1'b0;
    end else begin
      scl_sync_q <= {scl_sync_q[SYNC_STAGES-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SYNC_STAGES-2:0], sda_i};
      scl_o      <= scl_s;
      sda_o      <= sda_s;
      scl_rise_o <= scl_s && !scl_o;
      scl_fall_o <= !scl_s && scl_o;
      start_o    <= start_det && !bus_busy_q;
      rstart_o   <= start_det && bus_busy_q;
      stop_o     <= stop_det;
      if (stop_det) begin
        bus_busy_q <= 1'b0;
      end else if (start_det) begin
        bus_busy_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== bus_phy/bus_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_rx (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   sda_i,
  input  logic                   scl_rise_i,
  input  logic                   start_i,
  input  logic                   req_byte_i,
  input  logic                   req_bit_i,
  output i3c_daa_pkg::rx_byte_u  data_o,
  output logic                   done_o
);

  logic [7:0] shift_q;
  logic [2:0] bit_cnt_q;
  logic       req_active;
  logic       last_bit;

  assign req_active = req_byte_i || req_bit_i;

  // Single bit requests finish on the first edge
  assign last_bit = req_bit_i ? 1'b1 : (bit_cnt_q == 3'd7);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i || !req_active) begin
        bit_cnt_q <= '0;
      end else if (scl_rise_i) begin
        if (last_bit) begin
          bit_cnt_q <= '0;
          done_o    <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + 3'd1;
        end
      end
    end
  end

  // MSB first
  always_ff @(posedge clk_i) begin
    if (req_active && scl_rise_i) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
  end

  assign data_o = shift_q;

endmodule

`default_nettype wire

// ==== bus_phy/bus_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_tx (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic sda_i,
  input  logic scl_rise_i,
  input  logic scl_fall_i,
  input  logic req_bit_i,
  input  logic req_value_i,
  output logic sda_pull_o,
  output logic done_o,
  output logic arbitration_lost_o
);

  logic busy_q;
  logic settle_q;
  logic sampled_q;
  logic bit_end;
  logic load;

  assign bit_end = busy_q && scl_fall_i;
  assign done_o  = bit_end;

  // Released the line but someone else held it low
  assign arbitration_lost_o = bit_end && !sda_pull_o && !sampled_q;

  // Right after a bit ends SCL is still low, so the next bit can start at once
  assign load = !busy_q && req_bit_i && (scl_fall_i || settle_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      settle_q   <= 1'b0;
      sampled_q  <= 1'b1;
      sda_pull_o <= 1'b0;
    end else begin
      settle_q <= bit_end;
      if (load) begin
        busy_q     <= 1'b1;
        sda_pull_o <= !req_value_i;
      end else if (busy_q && !req_bit_i) begin
        // Request withdrawn, e.g. after STOP
        busy_q     <= 1'b0;
        sda_pull_o <= 1'b0;
      end else if (bit_end) begin
        busy_q <= 1'b0;
      end else if (settle_q) begin
        sda_pull_o <= 1'b0;
      end
      if (busy_q && scl_rise_i) begin
        sampled_q <= sda_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== ccc_entdaa/ccc_entdaa.sv ====
`timescale 1ns/1ps
`default_nettype none

module ccc_entdaa (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [47:0]           id_i,
  input  logic [7:0]            bcr_i,
  input  logic [7:0]            dcr_i,
  input  logic                  daa_en_i,
  input  i3c_daa_pkg::rx_byte_u rx_data_i,
  input  logic                  rx_done_i,
  input  logic                  tx_done_i,
  input  logic                  arbitration_lost_i,
  input  logic                  start_i,
  input  logic                  rstart_i,
  input  logic                  stop_i,
  output logic                  rx_req_byte_o,
  output logic                  rx_req_bit_o,
  output logic                  tx_req_bit_o,
  output logic                  tx_value_o,
  output logic [6:0]            address_o,
  output logic                  address_valid_o,
  output logic                  daa_error_o
);

  localparam int unsigned CNT_W = $clog2(i3c_daa_pkg::ID_BITS);

  localparam logic [3:0] ST_IDLE        = 4'd0;
  localparam logic [3:0] ST_RX_HDR      = 4'd1;
  localparam logic [3:0] ST_ACK_HDR     = 4'd2;
  localparam logic [3:0] ST_RX_CCC      = 4'd3;
  localparam logic [3:0] ST_RX_TBIT     = 4'd4;
  localparam logic [3:0] ST_WAIT_RSTART = 4'd5;
  localparam logic [3:0] ST_RX_HDR_R    = 4'd6;
  localparam logic [3:0] ST_ACK_HDR_R   = 4'd7;
  localparam logic [3:0] ST_ID_BIT      = 4'd8;
  localparam logic [3:0] ST_RX_ADDR     = 4'd9;
  localparam logic [3:0] ST_ACK_ADDR    = 4'd10;
  localparam logic [3:0] ST_NACK        = 4'd11;
  localparam logic [3:0] ST_DONE        = 4'd12;
  localparam logic [3:0] ST_ERROR       = 4'd13;

  logic [3:0]                       state_q;
  logic [3:0]                       state_d;
  logic [CNT_W-1:0]                 id_cnt_q;
  logic                             load_cnt;
  logic                             tick_cnt;
  logic [i3c_daa_pkg::ID_BITS-1:0]  device_id;
  logic                             hdr_wr_match;
  logic                             hdr_rd_match;
  logic                             parity_ok;

  assign device_id = {id_i, bcr_i, dcr_i};

  // Only answer the broadcast write while no address is held
  assign hdr_wr_match = (rx_data_i.hdr.addr == i3c_daa_pkg::RSVD_ADDR) &&
                        !rx_data_i.hdr.rnw && daa_en_i;
  assign hdr_rd_match = (rx_data_i.hdr.addr == i3c_daa_pkg::RSVD_ADDR) &&
                        rx_data_i.hdr.rnw;

  // Odd parity over address and parity bit
  assign parity_ok = ^{rx_data_i.daa.addr, rx_data_i.daa.parity};

  assign address_o = rx_data_i.daa.addr;

  always_comb begin
    state_d         = state_q;
    rx_req_byte_o   = 1'b0;
    rx_req_bit_o    = 1'b0;
    tx_req_bit_o    = 1'b0;
    tx_value_o      = 1'b0;
    address_valid_o = 1'b0;
    daa_error_o     = 1'b0;
    load_cnt        = 1'b0;
    tick_cnt        = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_RX_HDR;
        end
      end
      ST_RX_HDR: begin
        rx_req_byte_o = 1'b1;
        if (rx_done_i) begin
          state_d = hdr_wr_match ? ST_ACK_HDR : ST_DONE;
        end
      end
      ST_ACK_HDR: begin
        tx_req_bit_o = 1'b1;
        if (tx_done_i) begin
          state_d = ST_RX_CCC;
        end
      end
      ST_RX_CCC: begin
        rx_req_byte_o = 1'b1;
        if (rx_done_i) begin
          state_d = (rx_data_i == i3c_daa_pkg::CCC_ENTDAA) ? ST_RX_TBIT : ST_DONE;
        end
      end
      ST_RX_TBIT: begin
        // T-bit is optional here, a repeated START also moves on
        rx_req_bit_o = 1'b1;
        if (rstart_i) begin
          state_d = ST_RX_HDR_R;
        end else if (rx_done_i) begin
          state_d = ST_WAIT_RSTART;
        end
      end
      ST_WAIT_RSTART: begin
        if (rstart_i) begin
          state_d = ST_RX_HDR_R;
        end
      end
      ST_RX_HDR_R: begin
        rx_req_byte_o = 1'b1;
        if (rx_done_i) begin
          state_d = hdr_rd_match ? ST_ACK_HDR_R : ST_DONE;
        end
      end
      ST_ACK_HDR_R: begin
        tx_req_bit_o = 1'b1;
        if (tx_done_i) begin
          load_cnt = 1'b1;
          state_d  = ST_ID_BIT;
        end
      end
      ST_ID_BIT: begin
        tx_req_bit_o = 1'b1;
        tx_value_o   = device_id[id_cnt_q];
        if (tx_done_i) begin
          if (arbitration_lost_i) begin
            daa_error_o = 1'b1;
            state_d     = ST_ERROR;
          end else if (id_cnt_q == '0) begin
            state_d = ST_RX_ADDR;
          end else begin
            tick_cnt = 1'b1;
          end
        end
      end
      ST_RX_ADDR: begin
        rx_req_byte_o = 1'b1;
        if (rx_done_i) begin
          if (parity_ok) begin
            address_valid_o = 1'b1;
            state_d         = ST_ACK_ADDR;
          end else begin
            state_d = ST_NACK;
          end
        end
      end
      ST_ACK_ADDR: begin
        tx_req_bit_o = 1'b1;
        if (tx_done_i) begin
          state_d = ST_DONE;
        end
      end
      ST_NACK: begin
        tx_req_bit_o = 1'b1;
        tx_value_o   = 1'b1;
        if (tx_done_i) begin
          daa_error_o = 1'b1;
          state_d     = ST_ERROR;
        end
      end
      // Done and Error sit until STOP
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else if (stop_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ID bit index, MSB first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_cnt_q <= '0;
    end else if (load_cnt) begin
      id_cnt_q <= CNT_W'(i3c_daa_pkg::ID_BITS - 1);
    end else if (tick_cnt) begin
      id_cnt_q <= id_cnt_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/daa_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module daa_csr (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [4:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  input  logic [6:0]  address_i,
  input  logic        address_valid_i,
  input  logic        daa_error_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic [47:0] id_o,
  output logic [7:0]  bcr_o,
  output logic [7:0]  dcr_o,
  output logic        daa_en_o
);

  logic [47:0] pid_q;
  logic [7:0]  bcr_q;
  logic [7:0]  dcr_q;
  logic [6:0]  dyn_addr_q;
  logic        dyn_valid_q;
  logic        st_done_q;
  logic        st_err_q;
  logic        mapped;
  logic        wr_en;

  always_comb begin
    prdata_o = '0;
    mapped   = 1'b1;
    case (paddr_i)
      i3c_daa_pkg::CSR_PID_LO:   prdata_o = pid_q[31:0];
      i3c_daa_pkg::CSR_PID_HI:   prdata_o = {16'h0, pid_q[47:32]};
      i3c_daa_pkg::CSR_CHAR:     prdata_o = {16'h0, bcr_q, dcr_q};
      i3c_daa_pkg::CSR_DYN_ADDR: prdata_o = {24'h0, dyn_valid_q, dyn_addr_q};
      i3c_daa_pkg::CSR_STATUS:   prdata_o = {30'h0, st_err_q, st_done_q};
      default:                   mapped   = 1'b0;
    endcase
  end

  // No wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = psel_i && penable_i && !mapped;
  assign wr_en     = psel_i && penable_i && pwrite_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pid_q       <= '0;
      bcr_q       <= '0;
      dcr_q       <= '0;
      dyn_addr_q  <= '0;
      dyn_valid_q <= 1'b0;
      st_done_q   <= 1'b0;
      st_err_q    <= 1'b0;
    end else begin
      if (wr_en) begin
        case (paddr_i)
          i3c_daa_pkg::CSR_PID_LO: pid_q[31:0] <= pwdata_i;
          i3c_daa_pkg::CSR_PID_HI: pid_q[47:32] <= pwdata_i[15:0];
          i3c_daa_pkg::CSR_CHAR: begin
            bcr_q <= pwdata_i[15:8];
            dcr_q <= pwdata_i[7:0];
          end
          i3c_daa_pkg::CSR_DYN_ADDR: dyn_valid_q <= 1'b0;
          i3c_daa_pkg::CSR_STATUS: begin
            if (pwdata_i[0]) begin
              st_done_q <= 1'b0;
            end
            if (pwdata_i[1]) begin
              st_err_q <= 1'b0;
            end
          end
          default: begin
          end
        endcase
      end
      // Hardware events win over a clear in the same cycle
      if (address_valid_i) begin
        dyn_addr_q  <= address_i;
        dyn_valid_q <= 1'b1;
        st_done_q   <= 1'b1;
      end
      if (daa_error_i) begin
        st_err_q <= 1'b1;
      end
    end
  end

  assign id_o     = pid_q;
  assign bcr_o    = bcr_q;
  assign dcr_o    = dcr_q;
  assign daa_en_o = !dyn_valid_q;

endmodule

`default_nettype wire

// ==== design/i3c_daa_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i3c_daa_top #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        sda_pull_o,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [4:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o
);

  logic                  scl_s;
  logic                  sda_s;
  logic                  scl_rise;
  logic                  scl_fall;
  logic                  start_det;
  logic                  rstart_det;
  logic                  stop_det;
  i3c_daa_pkg::rx_byte_u rx_data;
  logic                  rx_done;
  logic                  rx_req_byte;
  logic                  rx_req_bit;
  logic                  tx_req_bit;
  logic                  tx_value;
  logic                  tx_done;
  logic                  arbitration_lost;
  logic [47:0]           id;
  logic [7:0]            bcr;
  logic [7:0]            dcr;
  logic                  daa_en;
  logic [6:0]            address;
  logic                  address_valid;
  logic                  daa_error;

  bus_monitor #(
    .SYNC_STAGES(SYNC_STAGES)
  ) i_bus_monitor (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .scl_o      (scl_s),
    .sda_o      (sda_s),
    .scl_rise_o (scl_rise),
    .scl_fall_o (scl_fall),
    .start_o    (start_det),
    .rstart_o   (rstart_det),
    .stop_o     (stop_det)
  );

  bus_rx i_bus_rx (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .sda_i      (sda_s),
    .scl_rise_i (scl_rise),
    .start_i    (start_det),
    .req_byte_i (rx_req_byte),
    .req_bit_i  (rx_req_bit),
    .data_o     (rx_data),
    .done_o     (rx_done)
  );

  ccc_entdaa i_ccc_entdaa (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .id_i               (id),
    .bcr_i              (bcr),
    .dcr_i              (dcr),
    .daa_en_i           (daa_en),
    .rx_data_i          (rx_data),
    .rx_done_i          (rx_done),
    .tx_done_i          (tx_done),
    .arbitration_lost_i (arbitration_lost),
    .start_i            (start_det),
    .rstart_i           (rstart_det),
    .stop_i             (stop_det),
    .rx_req_byte_o      (rx_req_byte),
    .rx_req_bit_o       (rx_req_bit),
    .tx_req_bit_o       (tx_req_bit),
    .tx_value_o         (tx_value),
    .address_o          (address),
    .address_valid_o    (address_valid),
    .daa_error_o        (daa_error)
  );

  bus_tx i_bus_tx (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .sda_i              (sda_s),
    .scl_rise_i         (scl_rise),
    .scl_fall_i         (scl_fall),
    .req_bit_i          (tx_req_bit),
    .req_value_i        (tx_value),
    .sda_pull_o         (sda_pull_o),
    .done_o             (tx_done),
    .arbitration_lost_o (arbitration_lost)
  );

  daa_csr i_daa_csr (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .address_i       (address),
    .address_valid_i (address_valid),
    .daa_error_i     (daa_error),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o),
    .id_o            (id),
    .bcr_o           (bcr),
    .dcr_o           (dcr),
    .daa_en_o        (daa_en)
  );

endmodule

`default_nettype wire

// ==== tests/i3c_daa_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module i3c_daa_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic address_valid_i,
  input logic sda_pull_i,
  input logic scl_s_i,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i
);

  // Address report is a single pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    address_valid_i |=> !address_valid_i)
    else $error("address_valid held longer than one cycle");

  // SDA only moves during the low phase of SCL
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sda_pull_i != $past(sda_pull_i)) |-> (!scl_s_i && !$past(scl_s_i)))
    else $error("sda_pull changed while SCL was high");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (psel_i && penable_i) |-> pready_i)
    else $error("pready low in an APB access phase");

endmodule

bind i3c_daa_top i3c_daa_assertions i_assertions (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .address_valid_i (address_valid),
  .sda_pull_i      (sda_pull_o),
  .scl_s_i         (scl_s),
  .psel_i          (psel_i),
  .penable_i       (penable_i),
  .pready_i        (pready_o)
);

`default_nettype wire

// ==== tests/tb_i3c_daa.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i3c_daa;

  localparam int N_TESTS  = 6;
  localparam int SEQ_BITS = 100;
  localparam int BIT_CLKS = 8;

  logic        clk;
  logic        rst_n;
  logic        scl;
  logic        sda_ctrl;
  logic        sda_bus;
  logic        sda_pull;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int          errors;
  int          test_errs;
  int          tests;
  logic [47:0] pid;
  logic [7:0]  bcr;
  logic [7:0]  dcr;

  // Open-drain line with pull-up
  assign sda_bus = sda_ctrl && !sda_pull;

  i3c_daa_top #(
    .SYNC_STAGES(2)
  ) i_dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .scl_i      (scl),
    .sda_i      (sda_bus),
    .sda_pull_o (sda_pull),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .pwdata_i   (pwdata),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .pslverr_o  (pslverr)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  initial begin
    repeat (N_TESTS * SEQ_BITS * BIT_CLKS * 2) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("Test FAILED");
    $finish;
  end

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error: %s expected %0b actual %0b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_byte(input string name, input i3c_daa_pkg::rx_byte_u exp,
                            input i3c_daa_pkg::rx_byte_u act);
    if (exp !== act) begin
      $display("** Error: %s expected %02h actual %02h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_id(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("** Error: %s expected %016h actual %016h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error: %s expected %08h actual %08h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("[%0d] %s finished with %0d errors", tests + 1, name, test_errs);
    errors += test_errs;
    test_errs = 0;
    tests++;
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    check_bit("apb write pready", 1'b1, pready);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                          output logic err);
    @(negedge clk);
    psel  = 1'b1;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    check_bit("apb read pready", 1'b1, pready);
    data    = prdata;
    err     = pslverr;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // One SCL period, 5 clocks low then 3 high; samples SDA at the end of high
  task automatic clock_bit(input logic v, output logic s);
    @(negedge clk);
    sda_ctrl = v;
    repeat (4) @(negedge clk);
    scl = 1'b1;
    repeat (3) @(negedge clk);
    s   = sda_bus;
    scl = 1'b0;
  endtask

  task automatic i3c_start();
    @(negedge clk);
    sda_ctrl = 1'b1;
    scl      = 1'b1;
    repeat (2) @(negedge clk);
    sda_ctrl = 1'b0;
    repeat (4) @(negedge clk);
    scl = 1'b0;
  endtask

  task automatic i3c_rstart();
    @(negedge clk);
    sda_ctrl = 1'b1;
    repeat (2) @(negedge clk);
    scl = 1'b1;
    repeat (3) @(negedge clk);
    sda_ctrl = 1'b0;
    repeat (3) @(negedge clk);
    scl = 1'b0;
  endtask

  task automatic i3c_stop();
    @(negedge clk);
    sda_ctrl = 1'b0;
    repeat (2) @(negedge clk);
    scl = 1'b1;
    repeat (3) @(negedge clk);
    sda_ctrl = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic i3c_write_byte(input logic [7:0] b);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(b[i], s);
    end
  endtask

  task automatic i3c_read_bit(output logic s);
    clock_bit(1'b1, s);
  endtask

  task automatic load_ids();
    pid = {16'($urandom) | 16'h0100, 32'($urandom)};
    bcr = 8'($urandom);
    dcr = 8'($urandom) | 8'h01;
    apb_write(i3c_daa_pkg::CSR_PID_LO, pid[31:0]);
    apb_write(i3c_daa_pkg::CSR_PID_HI, {16'h0, pid[47:32]});
    apb_write(i3c_daa_pkg::CSR_CHAR, {16'h0, bcr, dcr});
  endtask

  task automatic clear_target();
    apb_write(i3c_daa_pkg::CSR_DYN_ADDR, 32'h0);
    apb_write(i3c_daa_pkg::CSR_STATUS, 32'h3);
  endtask

  // Header 7E/W, ENTDAA code, T-bit, repeated START, 7E/R
  task automatic enter_entdaa(input string name, input logic hdr_ack);
    logic ack;
    i3c_start();
    i3c_write_byte({i3c_daa_pkg::RSVD_ADDR, 1'b0});
    i3c_read_bit(ack);
    check_bit({name, " 7E/W ack"}, !hdr_ack, ack);
    if (hdr_ack) begin
      i3c_write_byte(i3c_daa_pkg::CCC_ENTDAA);
      clock_bit(1'b0, ack);
      i3c_rstart();
      i3c_write_byte({i3c_daa_pkg::RSVD_ADDR, 1'b1});
      i3c_read_bit(ack);
      check_bit({name, " 7E/R ack"}, 1'b0, ack);
    end
  endtask

  task automatic send_address(input string name, input i3c_daa_pkg::rx_byte_u b,
                              input logic exp_ack);
    logic ack;
    i3c_write_byte(b);
    i3c_read_bit(ack);
    check_bit({name, " address ack"}, !exp_ack, ack);
  endtask

  task automatic full_entdaa(input string name, input logic [6:0] addr);
    logic [63:0]           id;
    logic [31:0]           rd;
    logic                  err;
    i3c_daa_pkg::rx_byte_u sent;
    i3c_daa_pkg::rx_byte_u got;
    sent = {addr, ~^addr};
    enter_entdaa(name, 1'b1);
    for (int i = 63; i >= 0; i--) begin
      i3c_read_bit(id[i]);
    end
    check_id({name, " id"}, {pid, bcr, dcr}, id);
    send_address(name, sent, 1'b1);
    i3c_stop();
    apb_read(i3c_daa_pkg::CSR_DYN_ADDR, rd, err);
    check_word({name, " dyn_addr"}, {24'h0, 1'b1, addr}, rd);
    got = {rd[6:0], ~^rd[6:0]};
    check_byte({name, " address"}, sent, got);
    apb_read(i3c_daa_pkg::CSR_STATUS, rd, err);
    check_word({name, " status"}, 32'h1, rd);
  endtask

  task automatic test_registers();
    logic [31:0] rd;
    logic        err;
    apb_read(i3c_daa_pkg::CSR_DYN_ADDR, rd, err);
    check_word("regs dyn_addr reset", 32'h0, rd);
    load_ids();
    apb_read(i3c_daa_pkg::CSR_PID_LO, rd, err);
    check_word("regs pid_lo", pid[31:0], rd);
    apb_read(i3c_daa_pkg::CSR_PID_HI, rd, err);
    check_word("regs pid_hi", {16'h0, pid[47:32]}, rd);
    apb_read(i3c_daa_pkg::CSR_CHAR, rd, err);
    check_word("regs char", {16'h0, bcr, dcr}, rd);
    check_bit("regs mapped slverr", 1'b0, err);
    apb_read(5'h14, rd, err);
    check_bit("regs unmapped slverr", 1'b1, err);
    finish_test("apb registers");
  endtask

  task automatic test_entdaa();
    clear_target();
    full_entdaa("entdaa", 7'($urandom));
    finish_test("successful entdaa");
  endtask

  task automatic test_bad_parity();
    logic [31:0]           rd;
    logic                  err;
    logic [63:0]           id;
    logic [6:0]            addr;
    i3c_daa_pkg::rx_byte_u bad;
    clear_target();
    addr = 7'($urandom);
    bad  = {addr, ^addr};
    enter_entdaa("parity", 1'b1);
    for (int i = 63; i >= 0; i--) begin
      i3c_read_bit(id[i]);
    end
    check_id("parity id", {pid, bcr, dcr}, id);
    send_address("parity", bad, 1'b0);
    i3c_stop();
    apb_read(i3c_daa_pkg::CSR_DYN_ADDR, rd, err);
    check_bit("parity dyn_addr valid", 1'b0, rd[7]);
    apb_read(i3c_daa_pkg::CSR_STATUS, rd, err);
    check_word("parity status", 32'h2, rd);
    finish_test("bad parity");
  endtask

  task automatic test_arbitration();
    logic [63:0] id;
    logic [31:0] rd;
    logic        err;
    logic        s;
    logic        v;
    int          k;
    clear_target();
    id = {pid, bcr, dcr};
    k  = 0;
    for (int i = 0; i < 64; i++) begin
      if (id[i]) begin
        k = i;
      end
    end
    enter_entdaa("arbitration", 1'b1);
    for (int i = 63; i >= 0; i--) begin
      if (i > k) begin
        clock_bit(1'b1, s);
        check_bit("arbitration leading bit", id[i], s);
      end else begin
        // Controller wins at bit k and owns the line from then on
        v = (i == k) ? 1'b0 : 1'($urandom);
        clock_bit(v, s);
        check_bit("arbitration controller bit", v, s);
      end
    end
    send_address("arbitration", {7'h3A, 1'b1}, 1'b0);
    i3c_stop();
    apb_read(i3c_daa_pkg::CSR_DYN_ADDR, rd, err);
    check_bit("arbitration dyn_addr valid", 1'b0, rd[7]);
    apb_read(i3c_daa_pkg::CSR_STATUS, rd, err);
    check_word("arbitration status", 32'h2, rd);
    finish_test("arbitration loss");
  endtask

  task automatic test_assigned();
    logic [31:0] rd;
    logic        err;
    logic [6:0]  first;
    first = 7'($urandom);
    clear_target();
    full_entdaa("assigned first", first);
    enter_entdaa("assigned blocked", 1'b0);
    i3c_stop();
    apb_read(i3c_daa_pkg::CSR_DYN_ADDR, rd, err);
    check_word("assigned unchanged", {24'h0, 1'b1, first}, rd);
    clear_target();
    full_entdaa("assigned again", first ^ 7'h55);
    finish_test("address already assigned");
  endtask

  task automatic test_stop_mid_id();
    logic [63:0] id;
    logic        s;
    logic        done;
    int          i;
    clear_target();
    id   = {pid, bcr, dcr};
    done = 1'b0;
    i    = 63;
    enter_entdaa("stop", 1'b1);
    // Stop once the next ID bit leaves SDA released
    while (!done && i >= 1) begin
      i3c_read_bit(s);
      check_bit("stop id bit", id[i], s);
      if (i <= 32 && id[i-1]) begin
        done = 1'b1;
      end
      i--;
    end
    i3c_stop();
    repeat (4) @(negedge clk);
    check_bit("stop sda released", 1'b0, sda_pull);
    apb_write(i3c_daa_pkg::CSR_STATUS, 32'h3);
    full_entdaa("stop fresh", 7'($urandom));
    finish_test("stop mid-sequence");
  endtask

  initial begin
    errors    = 0;
    test_errs = 0;
    tests     = 0;
    void'($urandom(16715));
    rst_n    = 1'b0;
    scl      = 1'b1;
    sda_ctrl = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_registers();
    test_entdaa();
    test_bad_parity();
    test_arbitration();
    test_assigned();
    test_stop_mid_id();

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== i3c_daa.f ====
common/i3c_daa_pkg.sv
bus_phy/bus_monitor.sv
bus_phy/bus_rx.sv
bus_phy/bus_tx.sv
ccc_entdaa/ccc_entdaa.sv
design/daa_csr.sv
design/i3c_daa_top.sv
tests/i3c_daa_assertions.sv
tests/tb_i3c_daa.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ENTDAA testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_i3c_daa \
  -f i3c_daa.f -Mdir obj_dir &&
  out="$(./obj_dir/Vtb_i3c_daa)" &&
  echo "$out" &&
  echo "$out" | grep -q "^Test OK$" || exit 1
